//--- bench/tb_x86_alu_core.sv
`timescale 1ns/1ns
`include "x86_dec_defines.svh"

module tb_x86_alu_core;

   localparam int N_DIRECTED = 40;
   localparam int N_RANDOM   = 240;
   // at most two cycles per instruction plus reset and drain
   localparam int MAX_CYCLES = 2*(N_DIRECTED + N_RANDOM) + 50;

   // one expected retirement
   typedef struct packed {
      logic        illegal;
      logic        wb_en;
      logic [2:0]  wb_reg;
      logic [31:0] wb_data;
      logic        st_valid;
      logic [31:0] st_addr;
      logic [31:0] st_data;
      logic        st_size16;
      logic        zf;
      logic        sf;
      logic        cf;
   } ret_t;

   logic                    clk;
   logic                    arst_n;
   logic                    insn_valid;
   logic [8*`WIN_BYTES-1:0] insn_bytes;
   logic                    retire_valid;
   logic                    retire_illegal;
   logic                    wb_en;
   logic [2:0]              wb_reg;
   logic [`REG_W-1:0]       wb_data;
   logic                    zf;
   logic                    sf;
   logic                    cf;
   logic                    st_valid;
   logic [`REG_W-1:0]       st_addr;
   logic [`REG_W-1:0]       st_data;
   logic                    st_size16;

   // reference model state
   logic [31:0]       lfsr;
   logic [`REG_W-1:0] regs_m [`NUM_REGS];
   logic              zf_m;
   logic              sf_m;
   logic              cf_m;
   ret_t              expq [$];
   ret_t              exp_r;
   int                mism_cnt = 0;
   int                fail_cnt = 0;
   int                n_sent = 0;
   int                n_retired = 0;
   int                cycles = 0;

   x86_alu_core DUT (.*);

   always #2 clk = ~clk;

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   // adc and sbb codes fold onto and and sub
   function automatic logic [2:0] alu_op_pick(input logic [2:0] k);
      return (k == 3'd2 || k == 3'd3) ? k + 3'd2 : k;
   endfunction

   // little endian value of len bytes starting off bytes past modrm
   function automatic logic [31:0] field_value(input logic [63:0] fld, input int off,
                                               input int len);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < len; k++) begin
         v[8*k +: 8] = fld[63-8*(off+k) -: 8];
      end
      if (len == 1) begin
         v = {{24{v[7]}}, v[7:0]};
      end
      return v;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
      mism_cnt++;
      $display("MISMATCH %0t %s got %h expected %h", $time, name, got, want);
   endtask

   task automatic note_failure(input string msg);
      fail_cnt++;
      $display("%0t: %s", $time, msg);
   endtask

   task automatic idle(input int n);
      repeat (n) @(negedge clk);
   endtask

   // encode, model and drive one instruction for a single cycle
   task automatic send(input logic pfx, input logic [7:0] opc, input logic [1:0] md,
                       input logic [2:0] rg, input logic [2:0] rm);
      logic [63:0] fld;
      logic [15:0] tail;
      logic        mem;
      logic        absolute;
      int          dlen;
      int          ilen;
      logic [31:0] disp;
      logic [31:0] imm;
      logic [31:0] ea;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] mask;
      logic [32:0] wide;
      ret_t        r;
      fld[63:32] = rand_bits(32);
      fld[31:0]  = rand_bits(32);
      tail       = 16'(rand_bits(16));
      mem        = md != 2'b11;
      absolute   = md == 2'b00 && rm == 3'd5;
      dlen = (md == 2'b01) ? 1 : (md == 2'b10 || absolute) ? 4 : 0;
      ilen = (opc == 8'h83) ? 1 : (opc == 8'h8d) ? 0 : (pfx ? 2 : 4);
      disp = field_value(fld, 0, dlen);
      imm  = field_value(fld, dlen, ilen);
      ea   = (absolute ? 32'h0 : regs_m[rm]) + disp;
      mask = pfx ? 32'h0000_ffff : 32'hffff_ffff;
      a    = regs_m[rm] & mask;
      b    = imm & mask;
      r    = '0;
      case (opc)
         8'h81, 8'h83: r.illegal = mem || rg == 3'd2 || rg == 3'd3;
         8'h8d:        r.illegal = !mem || rm == 3'd4;
         8'hc7:        r.illegal = rg != 3'd0 || (mem && rm == 3'd4);
         default:      r.illegal = 1'b1;
      endcase
      if (!r.illegal && opc == 8'h8d) begin
         r.wb_en   = 1'b1;
         r.wb_reg  = rg;
         r.wb_data = ea;
      end else if (!r.illegal && opc == 8'hc7 && mem) begin
         r.st_valid  = 1'b1;
         r.st_addr   = ea;
         r.st_data   = imm;
         r.st_size16 = pfx;
      end else if (!r.illegal && opc == 8'hc7) begin
         r.wb_en   = 1'b1;
         r.wb_reg  = rm;
         r.wb_data = imm;
      end else if (!r.illegal) begin
         case (rg)
            3'd0:    wide = {1'b0, a} + {1'b0, b};
            3'd1:    wide = {1'b0, a | b};
            3'd4:    wide = {1'b0, a & b};
            3'd6:    wide = {1'b0, a ^ b};
            default: wide = {1'b0, a} - {1'b0, b};
         endcase
         zf_m = (wide[31:0] & mask) == 32'h0;
         sf_m = pfx ? wide[15] : wide[31];
         cf_m = (rg == 3'd0) ? (pfx ? wide[16] : wide[32]) :
                (rg == 3'd5 || rg == 3'd7) ? a < b : 1'b0;
         // cmp only sets flags
         r.wb_en   = rg != 3'd7;
         r.wb_reg  = rm;
         r.wb_data = (regs_m[rm] & ~mask) | (wide[31:0] & mask);
      end
      if (r.wb_en) begin
         regs_m[r.wb_reg] = r.wb_data;
      end
      r.zf = zf_m;
      r.sf = sf_m;
      r.cf = cf_m;
      expq.push_back(r);
      insn_bytes = pfx ? {8'h66, opc, md, rg, rm, fld, tail[7:0]} : {opc, md, rg, rm, fld, tail};
      insn_valid = 1'b1;
      n_sent++;
      @(negedge clk);
      insn_valid = 1'b0;
   endtask

   // retirement popped at the falling edge and checked at the next rising edge
   always @(negedge clk) begin
      if (retire_valid) begin
         n_retired++;
         if (expq.size() == 0) begin
            note_failure("retirement with no instruction outstanding");
         end else begin
            exp_r = expq.pop_front();
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > MAX_CYCLES) begin
         $display("timeout after %0d cycles, %0d of %0d retired", cycles, n_retired, n_sent);
         $display("** FAIL **");
         $finish;
      end
   end

   assert property (@(posedge clk) !arst_n |-> !retire_valid && !wb_en && !st_valid)
      else note_failure("retire, write or store active during reset");
   assert property (@(posedge clk) disable iff (!arst_n) !retire_valid |-> !wb_en && !st_valid)
      else note_failure("write or store raised without a retirement");
   // strobe sampled at edge N is seen retiring in the sample of edge N+3
   assert property (@(posedge clk) disable iff (!arst_n) insn_valid |-> ##3 retire_valid)
      else note_failure("instruction did not retire three edges after its strobe");
   assert property (@(posedge clk) disable iff (!arst_n) !insn_valid |-> ##3 !retire_valid)
      else note_failure("retirement without a matching strobe");

   assert property (@(posedge clk) disable iff (!arst_n)
                    retire_valid |-> retire_illegal == exp_r.illegal)
      else report_mismatch("retire_illegal", 32'($sampled(retire_illegal)), 32'(exp_r.illegal));
   assert property (@(posedge clk) disable iff (!arst_n) retire_valid |-> wb_en == exp_r.wb_en)
      else report_mismatch("wb_en", 32'($sampled(wb_en)), 32'(exp_r.wb_en));
   assert property (@(posedge clk) disable iff (!arst_n) wb_en |-> wb_reg == exp_r.wb_reg)
      else report_mismatch("wb_reg", 32'($sampled(wb_reg)), 32'(exp_r.wb_reg));
   assert property (@(posedge clk) disable iff (!arst_n) wb_en |-> wb_data == exp_r.wb_data)
      else report_mismatch("wb_data", $sampled(wb_data), exp_r.wb_data);
   assert property (@(posedge clk) disable iff (!arst_n) retire_valid |-> zf == exp_r.zf)
      else report_mismatch("zf", 32'($sampled(zf)), 32'(exp_r.zf));
   assert property (@(posedge clk) disable iff (!arst_n) retire_valid |-> sf == exp_r.sf)
      else report_mismatch("sf", 32'($sampled(sf)), 32'(exp_r.sf));
   assert property (@(posedge clk) disable iff (!arst_n) retire_valid |-> cf == exp_r.cf)
      else report_mismatch("cf", 32'($sampled(cf)), 32'(exp_r.cf));
   assert property (@(posedge clk) disable iff (!arst_n)
                    retire_valid |-> st_valid == exp_r.st_valid)
      else report_mismatch("st_valid", 32'($sampled(st_valid)), 32'(exp_r.st_valid));
   assert property (@(posedge clk) disable iff (!arst_n) st_valid |-> st_addr == exp_r.st_addr)
      else report_mismatch("st_addr", $sampled(st_addr), exp_r.st_addr);
   assert property (@(posedge clk) disable iff (!arst_n) st_valid |-> st_data == exp_r.st_data)
      else report_mismatch("st_data", $sampled(st_data), exp_r.st_data);
   assert property (@(posedge clk) disable iff (!arst_n)
                    st_valid |-> st_size16 == exp_r.st_size16)
      else report_mismatch("st_size16", 32'($sampled(st_size16)), 32'(exp_r.st_size16));

   initial begin
      logic [2:0] sel;
      logic       pfx;
      logic [1:0] md;
      logic [2:0] rg;
      logic [2:0] rm;
      logic [7:0] opc;
      clk        = 1'b0;
      arst_n     = 1'b1;
      insn_valid = 1'b0;
      insn_bytes = '0;
      lfsr       = 32'hc69e5bca;
      zf_m       = 1'b0;
      sf_m       = 1'b0;
      cf_m       = 1'b0;
      exp_r      = '0;
      for (int i = 0; i < `NUM_REGS; i++) begin
         regs_m[i] = '0;
      end
      #1 arst_n = 1'b0;
      repeat (10) @(negedge clk);
      arst_n = 1'b1;
      idle(2);

      // r0 reads back zero after reset
      send(1'b0, 8'h8d, 2'b00, 3'd1, 3'd0);
      idle(2);
      // back to back lea with disp8, disp32 and absolute disp32
      send(1'b0, 8'hc7, 2'b11, 3'd0, 3'd2);
      send(1'b0, 8'h8d, 2'b01, 3'd3, 3'd2);
      send(1'b0, 8'h8d, 2'b10, 3'd4, 3'd3);
      send(1'b0, 8'h8d, 2'b00, 3'd5, 3'd5);
      // stores over every displacement and immediate length
      send(1'b0, 8'hc7, 2'b11, 3'd0, 3'd6);
      for (int p = 0; p < 2; p++) begin
         for (int m = 0; m < 3; m++) begin
            send(p[0], 8'hc7, m[1:0], 3'd0, 3'd6);
         end
         send(p[0], 8'hc7, 2'b00, 3'd0, 3'd5);
      end
      // dependent chain through r7
      send(1'b0, 8'hc7, 2'b11, 3'd0, 3'd7);
      for (int i = 0; i < 8; i++) begin
         send(i[0], i[1] ? 8'h81 : 8'h83, 2'b11, alu_op_pick(3'(i)), 3'd7);
      end
      send(1'b0, 8'h8d, 2'b01, 3'd6, 3'd7);
      send(1'b0, 8'h83, 2'b11, 3'd0, 3'd6);
      idle(2);
      // illegal forms
      send(1'b0, 8'h0f, 2'b11, 3'd0, 3'd0);
      send(1'b1, 8'hff, 2'b11, 3'd0, 3'd0);
      send(1'b0, 8'hc7, 2'b01, 3'd0, 3'd4);
      send(1'b0, 8'h8d, 2'b00, 3'd1, 3'd4);
      send(1'b0, 8'h8d, 2'b11, 3'd1, 3'd2);
      send(1'b0, 8'h81, 2'b10, 3'd0, 3'd1);
      send(1'b0, 8'h83, 2'b11, 3'd2, 3'd1);
      send(1'b0, 8'h81, 2'b11, 3'd3, 3'd1);
      send(1'b0, 8'hc7, 2'b11, 3'd4, 3'd1);

      // random mix of mostly group-1 forms
      for (int n = 0; n < N_RANDOM; n++) begin
         sel = 3'(rand_bits(3));
         pfx = 1'(rand_bits(1));
         md  = 2'(rand_bits(2));
         rg  = 3'(rand_bits(3));
         rm  = 3'(rand_bits(3));
         case (sel)
            3'd4: send(1'b0, 8'h8d, (md == 2'b11) ? 2'b01 : md, rg, rm);
            3'd5: send(1'b0, 8'hc7, 2'b11, 3'd0, rm);
            3'd6: send(pfx, 8'hc7, (md == 2'b11) ? 2'b10 : md, 3'd0, rm);
            3'd7: begin
               opc = 8'(rand_bits(8));
               send(pfx, (opc == 8'h66) ? 8'h67 : opc, md, rg, rm);
            end
            default: send(pfx, sel[0] ? 8'h81 : 8'h83, 2'b11, alu_op_pick(rg), rm);
         endcase
         if (rand_bits(2) == 32'h0) begin
            idle(1);
         end
      end

      // six cycles drain the fixed-depth pipeline
      idle(6);
      if (expq.size() != 0) begin
         note_failure("instructions still outstanding at the end of the run");
      end
      $display("retired %0d of %0d, %0d mismatches, %0d other errors",
               n_retired, n_sent, mism_cnt, fail_cnt);
      if (mism_cnt == 0 && fail_cnt == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- source/alu_execute.sv
`timescale 1ns/1ns
`include "x86_dec_defines.svh"

module alu_execute import x86_dec_pkg::*; (
   input  logic   clk,
   input  logic   arst_n,
   decoded_if.dst dec,
   reg_read_if.rd rd,
   exec_if.src    ex
);

   logic [`REG_W-1:0] dst_val;
   logic [`REG_W-1:0] base_val;
   logic [`REG_W-1:0] ea;
   logic [`REG_W:0]   sum;
   logic [`REG_W:0]   diff;
   logic [`REG_W-1:0] alu_res;
   logic [`REG_W-1:0] res;
   logic              cy;
   logic              live;

   assign rd.idx_a = dec.reg_idx;
   assign rd.idx_b = dec.rm_idx;

   // bypass the write still waiting in exec_if
   assign dst_val  = (ex.valid && ex.wb_en && ex.wb_reg == dec.reg_idx) ? ex.result
                                                                         : rd.data_a;
   assign base_val = (ex.valid && ex.wb_en && ex.wb_reg == dec.rm_idx) ? ex.result
                                                                        : rd.data_b;
   assign ea       = (dec.base_none ? '0 : base_val) + dec.disp;

   assign sum  = {1'b0, dst_val} + {1'b0, dec.imm};
   assign diff = {1'b0, dst_val} - {1'b0, dec.imm};

   always_comb begin
      cy = 1'b0;
      case (dec.alu_op)
         ALU_OR:  alu_res = dst_val | dec.imm;
         ALU_AND: alu_res = dst_val & dec.imm;
         ALU_XOR: alu_res = dst_val ^ dec.imm;
         ALU_SUB, ALU_CMP: begin
            alu_res = diff[`REG_W-1:0];
            // borrow into bit 16 falls out of the full-width difference
            cy = dec.size16 ? diff[16] ^ dst_val[16] ^ dec.imm[16] : diff[`REG_W];
         end
         default: begin
            alu_res = sum[`REG_W-1:0];
            cy = dec.size16 ? sum[16] ^ dst_val[16] ^ dec.imm[16] : sum[`REG_W];
         end
      endcase
   end

   // 16-bit ops leave the upper half alone
   assign res  = dec.size16 ? {dst_val[`REG_W-1:16], alu_res[15:0]} : alu_res;
   assign live = dec.valid && !dec.illegal;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex.valid    <= 1'b0;
         ex.wb_en    <= 1'b0;
         ex.flags_en <= 1'b0;
         ex.st_valid <= 1'b0;
      end else begin
         ex.valid    <= dec.valid;
         ex.wb_en    <= live && (dec.kind == K_LEA || dec.kind == K_MOV_REG ||
                                 (dec.kind == K_ALU && dec.alu_op != ALU_CMP));
         ex.flags_en <= live && dec.kind == K_ALU;
         ex.st_valid <= live && dec.kind == K_MOV_STORE;
      end
   end

   always_ff @(posedge clk) begin
      ex.illegal <= dec.illegal;
      ex.wb_reg  <= dec.reg_idx;
      ex.size16  <= dec.size16;
      ex.zf      <= dec.size16 ? res[15:0] == '0 : res == '0;
      ex.sf      <= dec.size16 ? res[15] : res[`REG_W-1];
      ex.cf      <= cy;
      ex.st_addr <= ea;
      ex.st_data <= dec.imm;
      case (dec.kind)
         K_ALU:   ex.result <= res;
         K_LEA:   ex.result <= ea;
         default: ex.result <= dec.imm;
      endcase
   end

endmodule

//--- source/imm_disp_separate.sv
`timescale 1ns/1ns
`include "x86_dec_defines.svh"

module imm_disp_separate (
   input  logic [8*`FIELD_BYTES-1:0] field_bytes,
   input  logic [2:0]                imm_bytes,
   input  logic [2:0]                disp_bytes,
   output logic [31:0]               disp,
   output logic [31:0]               imm
);

   logic [8*`FIELD_BYTES-1:0] swapped;
   logic [8*`FIELD_BYTES-1:0] imm_shift;

   // keep len bytes, a lone byte is sign-extended
   function automatic logic [31:0] extend(input logic [31:0] raw, input logic [2:0] len);
      logic [31:0] res;
      case (len)
         3'd1:    res = {{24{raw[7]}}, raw[7:0]};
         3'd2:    res = {16'h0000, raw[15:0]};
         3'd4:    res = raw;
         default: res = '0;
      endcase
      return res;
   endfunction

   // little endian fields, first fetched byte becomes the lsb
   always_comb begin
      for (int i = 0; i < `FIELD_BYTES; i++) begin
         swapped[8*i +: 8] = field_bytes[8*(`FIELD_BYTES-1-i) +: 8];
      end
   end

   // immediate starts right after the displacement
   assign imm_shift = swapped >> {disp_bytes, 3'b000};

   assign disp = extend(swapped[31:0], disp_bytes);
   assign imm  = extend(imm_shift[31:0], imm_bytes);

endmodule

//--- source/insn_decode.sv
`timescale 1ns/1ns
`include "x86_dec_defines.svh"

module insn_decode import x86_dec_pkg::*; (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    insn_valid,
   input  logic [8*`WIN_BYTES-1:0] insn_bytes,
   decoded_if.src                  dec
);

   localparam int TOP = 8*`WIN_BYTES - 1;

   logic                      has_pfx;
   logic [8*`WIN_BYTES-1:0]   win;
   opcode_e                   opc;
   logic [1:0]                mod_f;
   logic [2:0]                reg_f;
   logic [2:0]                rm_f;
   logic                      reg_form;
   logic [8*`FIELD_BYTES-1:0] field;
   logic [2:0]                disp_len;
   logic [2:0]                imm_len;
   logic                      illegal_c;
   insn_kind_e                kind_c;
   logic [31:0]               disp_c;
   logic [31:0]               imm_c;

   assign has_pfx = insn_bytes[TOP -: 8] == `OPSIZE_PREFIX;

   // drop the prefix so opcode and modrm line up at the top
   assign win      = has_pfx ? insn_bytes << 8 : insn_bytes;
   assign opc      = opcode_e'(win[TOP -: 8]);
   assign mod_f    = win[TOP-8 -: 2];
   assign reg_f    = win[TOP-10 -: 3];
   assign rm_f     = win[TOP-13 -: 3];
   assign field    = win[TOP-16 -: 8*`FIELD_BYTES];
   assign reg_form = mod_f == 2'b11;

   // mod 00 rm 101 is an absolute disp32
   always_comb begin
      case (mod_f)
         2'b00:   disp_len = (rm_f == 3'b101) ? 3'd4 : 3'd0;
         2'b01:   disp_len = 3'd1;
         2'b10:   disp_len = 3'd4;
         default: disp_len = 3'd0;
      endcase
   end

   always_comb begin
      kind_c    = K_ALU;
      imm_len   = has_pfx ? 3'd2 : 3'd4;
      illegal_c = 1'b1;
      case (opc)
         OP_GRP1_IV: begin
            illegal_c = !reg_form || reg_f == 3'd2 || reg_f == 3'd3;
         end
         OP_GRP1_IB: begin
            // imm8 sign-extended for either operand size
            imm_len   = 3'd1;
            illegal_c = !reg_form || reg_f == 3'd2 || reg_f == 3'd3;
         end
         OP_LEA: begin
            kind_c    = K_LEA;
            imm_len   = 3'd0;
            illegal_c = reg_form;
         end
         OP_MOV_IV: begin
            kind_c    = reg_form ? K_MOV_REG : K_MOV_STORE;
            illegal_c = reg_f != 3'd0;
         end
         default: begin
            illegal_c = 1'b1;
         end
      endcase
      // sib byte not supported
      if (!reg_form && rm_f == 3'b100) begin
         illegal_c = 1'b1;
      end
   end

   imm_disp_separate u_separate (
      .field_bytes (field),
      .imm_bytes   (imm_len),
      .disp_bytes  (disp_len),
      .disp        (disp_c),
      .imm         (imm_c)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dec.valid <= 1'b0;
      end else begin
         dec.valid <= insn_valid;
      end
   end

   always_ff @(posedge clk) begin
      dec.illegal   <= illegal_c;
      dec.kind      <= kind_c;
      dec.alu_op    <= alu_op_e'(reg_f);
      dec.size16    <= has_pfx;
      // lea writes modrm reg, every other form writes modrm rm
      dec.reg_idx   <= (opc == OP_LEA) ? reg_f : rm_f;
      dec.rm_idx    <= rm_f;
      dec.base_none <= mod_f == 2'b00 && rm_f == 3'b101;
      dec.disp      <= disp_c;
      dec.imm       <= imm_c;
   end

endmodule

//--- source/result_writeback.sv
`timescale 1ns/1ns
`include "x86_dec_defines.svh"

module result_writeback (
   input  logic                         clk,
   input  logic                         arst_n,
   exec_if.dst                          ex,
   reg_read_if.rf                       rf,
   output logic                         retire_valid,
   output logic                         retire_illegal,
   output logic                         wb_en,
   output logic [$clog2(`NUM_REGS)-1:0] wb_reg,
   output logic [`REG_W-1:0]            wb_data,
   output logic                         zf,
   output logic                         sf,
   output logic                         cf,
   output logic                         st_valid,
   output logic [`REG_W-1:0]            st_addr,
   output logic [`REG_W-1:0]            st_data,
   output logic                         st_size16
);

   logic [`REG_W-1:0] regs [`NUM_REGS];
   logic              commit;

   // read ports see the file before this cycle's write
   assign rf.data_a = regs[rf.idx_a];
   assign rf.data_b = regs[rf.idx_b];

   // an illegal instruction retires but touches no state
   assign commit = ex.valid && !ex.illegal;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
         zf             <= 1'b0;
         sf             <= 1'b0;
         cf             <= 1'b0;
         retire_valid   <= 1'b0;
         retire_illegal <= 1'b0;
         wb_en          <= 1'b0;
         st_valid       <= 1'b0;
      end else begin
         if (commit && ex.wb_en) begin
            regs[ex.wb_reg] <= ex.result;
         end
         if (commit && ex.flags_en) begin
            zf <= ex.zf;
            sf <= ex.sf;
            cf <= ex.cf;
         end
         retire_valid   <= ex.valid;
         retire_illegal <= ex.valid && ex.illegal;
         wb_en          <= commit && ex.wb_en;
         st_valid       <= commit && ex.st_valid;
      end
   end

   // retire payload, qualified by the strobes above
   always_ff @(posedge clk) begin
      wb_reg    <= ex.wb_reg;
      wb_data   <= ex.result;
      st_addr   <= ex.st_addr;
      st_data   <= ex.st_data;
      st_size16 <= ex.size16;
   end

endmodule

//--- source/stage_ifs.sv
`timescale 1ns/1ns
`include "x86_dec_defines.svh"

// decode stage to execute stage
interface decoded_if import x86_dec_pkg::*; ();
   logic                         valid;
   logic                         illegal;
   insn_kind_e                   kind;
   alu_op_e                      alu_op;
   logic                         size16;
   // destination register
   logic [$clog2(`NUM_REGS)-1:0] reg_idx;
   // base register for memory forms
   logic [$clog2(`NUM_REGS)-1:0] rm_idx;
   logic                         base_none;
   logic [`REG_W-1:0]            disp;
   logic [`REG_W-1:0]            imm;

   modport src (output valid, illegal, kind, alu_op, size16, reg_idx, rm_idx,
                base_none, disp, imm);
   modport dst (input valid, illegal, kind, alu_op, size16, reg_idx, rm_idx,
                base_none, disp, imm);
endinterface

// execute stage to result stage
interface exec_if ();
   logic                         valid;
   logic                         illegal;
   logic                         wb_en;
   logic [$clog2(`NUM_REGS)-1:0] wb_reg;
   logic [`REG_W-1:0]            result;
   logic                         flags_en;
   logic                         zf;
   logic                         sf;
   logic                         cf;
   logic                         st_valid;
   logic [`REG_W-1:0]            st_addr;
   logic [`REG_W-1:0]            st_data;
   logic                         size16;

   modport src (output valid, illegal, wb_en, wb_reg, result, flags_en, zf, sf, cf,
                st_valid, st_addr, st_data, size16);
   modport dst (input valid, illegal, wb_en, wb_reg, result, flags_en, zf, sf, cf,
                st_valid, st_addr, st_data, size16);
endinterface

// two asynchronous register file read ports
interface reg_read_if ();
   logic [$clog2(`NUM_REGS)-1:0] idx_a;
   logic [$clog2(`NUM_REGS)-1:0] idx_b;
   logic [`REG_W-1:0]            data_a;
   logic [`REG_W-1:0]            data_b;

   modport rd (output idx_a, idx_b, input data_a, data_b);
   modport rf (input idx_a, idx_b, output data_a, data_b);
endinterface

//--- source/x86_alu_core.sv
`timescale 1ns/1ns
`include "x86_dec_defines.svh"

module x86_alu_core (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         insn_valid,
   input  logic [8*`WIN_BYTES-1:0]      insn_bytes,
   output logic                         retire_valid,
   output logic                         retire_illegal,
   output logic                         wb_en,
   output logic [$clog2(`NUM_REGS)-1:0] wb_reg,
   output logic [`REG_W-1:0]            wb_data,
   output logic                         zf,
   output logic                         sf,
   output logic                         cf,
   output logic                         st_valid,
   output logic [`REG_W-1:0]            st_addr,
   output logic [`REG_W-1:0]            st_data,
   output logic                         st_size16
);

   decoded_if  dec_bus ();
   exec_if     ex_bus ();
   reg_read_if rr_bus ();

   // decode -> execute -> result, one instruction per stage
   insn_decode u_decode (
      .clk        (clk),
      .arst_n     (arst_n),
      .insn_valid (insn_valid),
      .insn_bytes (insn_bytes),
      .dec        (dec_bus.src)
   );

   alu_execute u_execute (
      .clk    (clk),
      .arst_n (arst_n),
      .dec    (dec_bus.dst),
      .rd     (rr_bus.rd),
      .ex     (ex_bus.src)
   );

   result_writeback u_result (
      .clk            (clk),
      .arst_n         (arst_n),
      .ex             (ex_bus.dst),
      .rf             (rr_bus.rf),
      .retire_valid   (retire_valid),
      .retire_illegal (retire_illegal),
      .wb_en          (wb_en),
      .wb_reg         (wb_reg),
      .wb_data        (wb_data),
      .zf             (zf),
      .sf             (sf),
      .cf             (cf),
      .st_valid       (st_valid),
      .st_addr        (st_addr),
      .st_data        (st_data),
      .st_size16      (st_size16)
   );

endmodule

//--- source/x86_dec_defines.svh
`ifndef X86_DEC_DEFINES_SVH
`define X86_DEC_DEFINES_SVH

// fetch window, byte 0 sits in the top byte lane
`define WIN_BYTES 12

// displacement plus immediate bytes after modrm
`define FIELD_BYTES 8

// architectural register file
`define NUM_REGS 8
`define REG_W 32

// operand-size override
`define OPSIZE_PREFIX 8'h66

`endif

//--- source/x86_dec_pkg.sv
package x86_dec_pkg;

   // supported primary opcodes
   typedef enum logic [7:0] {
      OP_GRP1_IV = 8'h81,
      OP_GRP1_IB = 8'h83,
      OP_LEA     = 8'h8d,
      OP_MOV_IV  = 8'hc7
   } opcode_e;

   // group-1 operation, taken straight from modrm reg
   // 2 and 3 (adc, sbb) have no entry
   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_OR  = 3'd1,
      ALU_AND = 3'd4,
      ALU_SUB = 3'd5,
      ALU_XOR = 3'd6,
      ALU_CMP = 3'd7
   } alu_op_e;

   // what the execute stage does with the instruction
   typedef enum logic [1:0] {
      K_ALU,
      K_LEA,
      K_MOV_REG,
      K_MOV_STORE
   } insn_kind_e;

endpackage

//--- sources.f
+incdir+source
source/x86_dec_pkg.sv
source/stage_ifs.sv
source/imm_disp_separate.sv
source/insn_decode.sv
source/alu_execute.sv
source/result_writeback.sv
source/x86_alu_core.sv
bench/tb_x86_alu_core.sv
